// ==== test/testdata_keys.txt ====
# name  scan_code_hex  corrupt_parity  expected_ascii_hex_or_none
# One PS/2 frame per line, sent back to back in this order
a_make         1C 0 61
a_brk_prefix   F0 0 none
a_brk          1C 0 none
lshift_make    12 0 none
b_upper        32 0 42
b_brk_prefix   F0 0 none
b_brk          32 0 none
lshift_prefix  F0 0 none
lshift_brk     12 0 none
c_lower        21 0 63
space          29 0 20
bad_parity     1D 1 none
ext_prefix     E0 0 none
ext_code       75 0 none
unmapped       05 0 none
rshift_make    59 0 none
z_upper        1A 0 5a
rshift_prefix  F0 0 none
rshift_brk     59 0 none
z_lower        1A 0 7a
burst_1        16 0 31
burst_2        1E 0 32
burst_3        26 0 33
digit_0        45 0 30
enter          5A 0 0d

// ==== tb.f ====
verilog/board_pkg.sv
verilog/ps2_frame_rx.sv
verilog/key_translate.sv
verilog/bus_master.sv
verilog/bus_fabric.sv
verilog/uart_tx.sv
verilog/keyboard_console.sv
test/tb_keyboard_console.sv

// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f tb.f --top-module tb_keyboard_console -Mdir obj_dir

run: compile
	./obj_dir/Vtb_keyboard_console | tee /dev/stderr | grep -F "ALL CHECKS PASSED" > /dev/null

clean:
	rm -rf obj_dir

// ==== test/tb_keyboard_console.sv ====
`timescale 1ns/1ps

module tb_keyboard_console
    import board_pkg::*;
();

    // UART frame (10 x 48 cycles) outlasts one PS/2 frame (440 cycles)
    localparam int unsigned uart_div = 48;
    localparam int unsigned ps2_half = 20;

    logic       CLOCK_50;
    logic       arst_n;
    logic       ps2_clk;
    logic       ps2_dat;
    logic       uart_txd;
    ascii_t     ledg;
    logic [7:0] ledr;

    // Frames to send, one per data line
    string  name_q[$];
    scan_t  code_q[$];
    logic   corrupt_q[$];
    // Characters still due on the UART, in file order
    ascii_t exp_q[$];
    string  exp_name_q[$];
    ascii_t last_exp = 8'h00;
    int     exp_total = 0;
    int     rx_count = 0;
    longint limit;

    keyboard_console #(
        .uart_div (uart_div)
    ) keyboard_console_inst (
        .CLOCK_50 (CLOCK_50),
        .arst_n   (arst_n),
        .ps2_clk  (ps2_clk),
        .ps2_dat  (ps2_dat),
        .uart_txd (uart_txd),
        .ledg     (ledg),
        .ledr     (ledr)
    );

    always #4 CLOCK_50 = ~CLOCK_50;

    task automatic fail_run();
        $display("CHECKS FAILED");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic check_ascii(input string test, input ascii_t exp, input ascii_t act);
        if (act !== exp) begin
            $display("Error %s: expected 0x%02h, actual 0x%02h", test, exp, act);
            fail_run();
        end
    endtask

    task automatic check_count(input string test, input logic [7:0] exp,
                               input logic [7:0] act);
        if (act !== exp) begin
            $display("Error %s: expected %0d, actual %0d", test, exp, act);
            fail_run();
        end
    endtask

    // Skips comment lines, expected column is hex or none
    task automatic load_vectors();
        int         fd;
        int         n;
        int         corrupt;
        string      line;
        string      name;
        string      exp_s;
        logic [7:0] code;
        logic [7:0] ch;
        fd = $fopen("test/testdata_keys.txt", "r");
        if (fd == 0) begin
            $display("Could not open test/testdata_keys.txt");
            fail_run();
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") continue;
            n = $sscanf(line, "%s %h %d %s", name, code, corrupt, exp_s);
            if (n != 4) begin
                $display("Data file line could not be parsed: %s", line);
                fail_run();
            end
            name_q.push_back(name);
            code_q.push_back(code);
            corrupt_q.push_back(corrupt != 0);
            if (exp_s != "none") begin
                void'($sscanf(exp_s, "%h", ch));
                exp_q.push_back(ch);
                exp_name_q.push_back(name);
                last_exp = ch;
            end
        end
        $fclose(fd);
    endtask

    // Start, 8 data LSB first, odd parity, stop
    task automatic send_frame(input scan_t code, input logic corrupt);
        logic [10:0] bits;
        logic        parity;
        parity = ~^code;
        if (corrupt) parity = ~parity;
        bits = {1'b1, parity, code, 1'b0};
        for (int i = 0; i < 11; i++) begin
            @(posedge CLOCK_50);
            ps2_dat <= bits[i];
            repeat (ps2_half - 1) @(posedge CLOCK_50);
            // Keyboard side samples on this falling edge
            ps2_clk <= 1'b0;
            repeat (ps2_half) @(posedge CLOCK_50);
            ps2_clk <= 1'b1;
        end
    endtask

    // UART receiver, samples mid-bit on the falling clock edge
    initial begin : uart_monitor
        ascii_t rx_byte;
        ascii_t exp;
        string  test;
        wait (arst_n === 1'b1);
        forever begin
            @(negedge uart_txd);
            repeat (uart_div / 2) @(negedge CLOCK_50);
            if (uart_txd !== 1'b0) begin
                $display("UART start bit did not stay low");
                fail_run();
            end
            for (int b = 0; b < 8; b++) begin
                repeat (uart_div) @(negedge CLOCK_50);
                rx_byte[b] = uart_txd;
            end
            repeat (uart_div) @(negedge CLOCK_50);
            if (uart_txd !== 1'b1) begin
                $display("UART stop bit was not high");
                fail_run();
            end
            if (exp_q.size() == 0) begin
                $display("UART sent byte 0x%02h that no test line expected", rx_byte);
                fail_run();
            end
            exp  = exp_q.pop_front();
            test = exp_name_q.pop_front();
            rx_count++;
            check_ascii(test, exp, rx_byte);
            // LED write lands right after the UART takes the byte
            check_ascii({test, "_ledg"}, exp, ledg);
            check_count({test, "_ledr"}, 8'(rx_count), ledr);
        end
    end

    initial begin : main_seq
        CLOCK_50 = 1'b0;
        arst_n   = 1'b0;
        ps2_clk  = 1'b1;
        ps2_dat  = 1'b1;
        load_vectors();
        exp_total = exp_q.size();
        // Frame time plus one UART frame per line, four times over
        limit = longint'(name_q.size()) * (22 * ps2_half + 12 * uart_div) * 4;
        if (limit > 1000000) limit = 1000000;
        fork
            begin : watchdog
                repeat (limit) @(posedge CLOCK_50);
                $display("Timeout, the run did not finish within %0d cycles", limit);
                fail_run();
            end
        join_none
        repeat (4) @(posedge CLOCK_50);
        arst_n <= 1'b1;
        @(negedge CLOCK_50);
        check_ascii("reset_ledg", 8'h00, ledg);
        check_count("reset_ledr", 8'h00, ledr);
        // Frames go out back to back
        foreach (name_q[i]) begin
            send_frame(code_q[i], corrupt_q[i]);
        end
        wait (rx_count == exp_total);
        // Room for a stray extra byte to show up
        repeat (24 * uart_div) @(posedge CLOCK_50);
        @(negedge CLOCK_50);
        check_ascii("final_ledg", last_exp, ledg);
        check_count("final_ledr", 8'(exp_total), ledr);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// ==== verilog/keyboard_console.sv ====
`timescale 1ns/1ps

module keyboard_console
    import board_pkg::*;
#(
    parameter int unsigned uart_div = uart_div_default
) (
    input  logic       CLOCK_50,
    input  logic       arst_n,
    input  logic       ps2_clk,
    input  logic       ps2_dat,
    output logic       uart_txd,
    output ascii_t     ledg,
    output logic [7:0] ledr
);

    scan_t    scan;
    logic     scan_valid;
    key_evt_t evt;
    wb_req_t  m_req;
    wb_rsp_t  m_rsp;
    wb_req_t  uart_req;
    wb_rsp_t  uart_rsp;

    // Decode, frames to scan codes
    ps2_frame_rx ps2_frame_rx_inst (
        .CLOCK_50   (CLOCK_50),
        .arst_n     (arst_n),
        .ps2_clk    (ps2_clk),
        .ps2_dat    (ps2_dat),
        .scan       (scan),
        .scan_valid (scan_valid)
    );

    // Execute, scan codes to ASCII
    key_translate key_translate_inst (
        .CLOCK_50   (CLOCK_50),
        .arst_n     (arst_n),
        .scan       (scan),
        .scan_valid (scan_valid),
        .evt        (evt)
    );

    // Result, characters onto the bus
    bus_master bus_master_inst (
        .CLOCK_50 (CLOCK_50),
        .arst_n   (arst_n),
        .evt      (evt),
        .wb_req   (m_req),
        .wb_rsp   (m_rsp)
    );

    bus_fabric bus_fabric_inst (
        .CLOCK_50 (CLOCK_50),
        .arst_n   (arst_n),
        .wb_req   (m_req),
        .wb_rsp   (m_rsp),
        .uart_req (uart_req),
        .uart_rsp (uart_rsp),
        .ledg     (ledg),
        .ledr     (ledr)
    );

    uart_tx #(
        .uart_div (uart_div)
    ) uart_tx_inst (
        .CLOCK_50 (CLOCK_50),
        .arst_n   (arst_n),
        .wb_req   (uart_req),
        .wb_rsp   (uart_rsp),
        .txd      (uart_txd)
    );

endmodule

// ==== verilog/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx
    import board_pkg::*;
#(
    parameter int unsigned uart_div = uart_div_default
) (
    input  logic    CLOCK_50,
    input  logic    arst_n,
    input  wb_req_t wb_req,
    output wb_rsp_t wb_rsp,
    output logic    txd
);

    localparam int unsigned div_w = (uart_div > 1) ? $clog2(uart_div) : 1;

    typedef enum logic {
        st_idle,
        st_shifting
    } tx_state_t;

    tx_state_t  state;
    logic [9:0] shreg;
    logic [3:0] bit_cnt;
    logic [div_w-1:0] div_cnt;
    logic       ack_q;
    logic       wr_req;

    assign wr_req = wb_req.cyc & wb_req.stb & wb_req.we;

    always_ff @(posedge CLOCK_50 or negedge arst_n) begin
        if (!arst_n) begin
            state   <= st_idle;
            bit_cnt <= '0;
            div_cnt <= '0;
            ack_q   <= 1'b0;
        end else begin
            ack_q <= 1'b0;
            case (state)
                st_idle: begin
                    // Take the byte only when free, this is the back-pressure
                    if (wr_req) begin
                        ack_q   <= 1'b1;
                        bit_cnt <= '0;
                        div_cnt <= '0;
                        state   <= st_shifting;
                    end
                end
                default: begin
                    if (div_cnt == div_w'(uart_div - 1)) begin
                        div_cnt <= '0;
                        // Stop bit done after bit 9
                        if (bit_cnt == 4'd9) begin
                            state <= st_idle;
                        end else begin
                            bit_cnt <= bit_cnt + 4'd1;
                        end
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // Frame is stop, data LSB first, start in bit 0
    always_ff @(posedge CLOCK_50) begin
        if (state == st_idle && wr_req) begin
            shreg <= {1'b1, wb_req.dat[7:0], 1'b0};
        end else if (state == st_shifting && div_cnt == div_w'(uart_div - 1)) begin
            shreg <= {1'b1, shreg[9:1]};
        end
    end

    assign txd        = (state == st_shifting) ? shreg[0] : 1'b1;
    assign wb_rsp.ack = ack_q;

endmodule

// ==== verilog/bus_fabric.sv ====
`timescale 1ns/1ps

module bus_fabric
    import board_pkg::*;
(
    input  logic       CLOCK_50,
    input  logic       arst_n,
    input  wb_req_t    wb_req,
    output wb_rsp_t    wb_rsp,
    output wb_req_t    uart_req,
    input  wb_rsp_t    uart_rsp,
    output ascii_t     ledg,
    output logic [7:0] ledr
);

    logic uart_sel;
    logic led_sel;
    logic req_live;
    logic local_ack;

    // Full address compare, no aliasing
    assign uart_sel = (wb_req.adr == uart_base);
    assign led_sel  = (wb_req.adr == led_base);
    assign req_live = wb_req.cyc & wb_req.stb;

    // UART only sees its own strobe
    always_comb begin
        uart_req     = wb_req;
        uart_req.stb = wb_req.stb & uart_sel;
    end

    // LED slave and the unmapped catch-all share one ack flop
    always_ff @(posedge CLOCK_50 or negedge arst_n) begin
        if (!arst_n) begin
            local_ack <= 1'b0;
            ledg      <= '0;
            ledr      <= '0;
        end else begin
            local_ack <= req_live & ~uart_sel & ~local_ack;
            if (req_live && wb_req.we && led_sel && !local_ack) begin
                ledg <= wb_req.dat[7:0];
                // Delivered count, wraps at 256
                ledr <= ledr + 8'd1;
            end
        end
    end

    assign wb_rsp.ack = uart_sel ? uart_rsp.ack : local_ack;

endmodule

// ==== verilog/bus_master.sv ====
`timescale 1ns/1ps

module bus_master
    import board_pkg::*;
(
    input  logic     CLOCK_50,
    input  logic     arst_n,
    input  key_evt_t evt,
    output wb_req_t  wb_req,
    input  wb_rsp_t  wb_rsp
);

    typedef enum logic [1:0] {
        st_idle,
        st_write_uart,
        st_write_led
    } bm_state_t;

    bm_state_t state;
    ascii_t    pending;

    always_ff @(posedge CLOCK_50 or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle:       if (evt.valid) state <= st_write_uart;
                // LED write follows right after the UART ack
                st_write_uart: if (wb_rsp.ack) state <= st_write_led;
                st_write_led:  if (wb_rsp.ack) state <= st_idle;
                default:       state <= st_idle;
            endcase
        end
    end

    // Character only loaded when free, later events are dropped
    always_ff @(posedge CLOCK_50) begin
        if (state == st_idle && evt.valid) begin
            pending <= evt.ascii;
        end
    end

    // Request held steady for the whole cycle
    always_comb begin
        wb_req.cyc = (state != st_idle);
        wb_req.stb = (state != st_idle);
        wb_req.we  = 1'b1;
        wb_req.adr = (state == st_write_led) ? led_base : uart_base;
        wb_req.dat = {24'h0, pending};
    end

endmodule

// ==== verilog/key_translate.sv ====
`timescale 1ns/1ps

module key_translate
    import board_pkg::*;
(
    input  logic     CLOCK_50,
    input  logic     arst_n,
    input  scan_t    scan,
    input  logic     scan_valid,
    output key_evt_t evt
);

    typedef enum logic [1:0] {
        st_idle,
        st_break_seen,
        st_ext_seen,
        st_ext_break_seen
    } kt_state_t;

    kt_state_t state;
    logic      shift;
    ascii_t    base_char;
    ascii_t    out_char;
    logic      is_shift_key;

    // Set 2 make code to lower case ASCII, zero when unmapped
    function automatic ascii_t lookup(input scan_t code);
        ascii_t c;
        case (code)
            8'h1C: c = "a";  8'h32: c = "b";  8'h21: c = "c";  8'h23: c = "d";
            8'h24: c = "e";  8'h2B: c = "f";  8'h34: c = "g";  8'h33: c = "h";
            8'h43: c = "i";  8'h3B: c = "j";  8'h42: c = "k";  8'h4B: c = "l";
            8'h3A: c = "m";  8'h31: c = "n";  8'h44: c = "o";  8'h4D: c = "p";
            8'h15: c = "q";  8'h2D: c = "r";  8'h1B: c = "s";  8'h2C: c = "t";
            8'h3C: c = "u";  8'h2A: c = "v";  8'h1D: c = "w";  8'h22: c = "x";
            8'h35: c = "y";  8'h1A: c = "z";
            8'h45: c = "0";  8'h16: c = "1";  8'h1E: c = "2";  8'h26: c = "3";
            8'h25: c = "4";  8'h2E: c = "5";  8'h36: c = "6";  8'h3D: c = "7";
            8'h3E: c = "8";  8'h46: c = "9";
            8'h29: c = " ";
            // Enter sends carriage return
            8'h5A: c = 8'h0D;
            default: c = 8'h00;
        endcase
        return c;
    endfunction

    assign base_char    = lookup(scan);
    assign is_shift_key = (scan == 8'h12) || (scan == 8'h59);

    // Only letters change case
    assign out_char = (shift && base_char >= "a" && base_char <= "z") ?
                      base_char - 8'h20 : base_char;

    always_ff @(posedge CLOCK_50 or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
            shift <= 1'b0;
            evt   <= '0;
        end else begin
            evt.valid <= 1'b0;
            if (scan_valid) begin
                case (state)
                    st_idle: begin
                        if (scan == 8'hF0) begin
                            state <= st_break_seen;
                        end else if (scan == 8'hE0) begin
                            state <= st_ext_seen;
                        end else if (is_shift_key) begin
                            shift <= 1'b1;
                        end else if (base_char != 8'h00) begin
                            evt.valid <= 1'b1;
                            evt.ascii <= out_char;
                        end
                    end
                    st_break_seen: begin
                        // Release of a shift key, other releases ignored
                        if (is_shift_key) begin
                            shift <= 1'b0;
                        end
                        state <= st_idle;
                    end
                    st_ext_seen: begin
                        state <= (scan == 8'hF0) ? st_ext_break_seen : st_idle;
                    end
                    default: begin
                        state <= st_idle;
                    end
                endcase
            end
        end
    end

endmodule

// ==== verilog/ps2_frame_rx.sv ====
`timescale 1ns/1ps

module ps2_frame_rx
    import board_pkg::*;
(
    input  logic  CLOCK_50,
    input  logic  arst_n,
    input  logic  ps2_clk,
    input  logic  ps2_dat,
    output scan_t scan,
    output logic  scan_valid
);

    // Two-flop synchronizers, plus one more stage on clock for edge detect
    logic [1:0]  clk_sync;
    logic [1:0]  dat_sync;
    logic        clk_prev;
    logic        clk_fall;

    // Frame assembly
    logic [10:0] frame;
    logic [10:0] frame_next;
    logic [3:0]  bit_cnt;
    logic        frame_ok;

    always_ff @(posedge CLOCK_50 or negedge arst_n) begin
        if (!arst_n) begin
            // Idle bus is high on both lines
            clk_sync <= 2'b11;
            dat_sync <= 2'b11;
            clk_prev <= 1'b1;
        end else begin
            clk_sync <= {clk_sync[0], ps2_clk};
            dat_sync <= {dat_sync[0], ps2_dat};
            clk_prev <= clk_sync[1];
        end
    end

    // High for one cycle after the synchronized clock drops
    assign clk_fall = clk_prev & ~clk_sync[1];

    // New bit enters at the top, so start ends up in bit 0
    assign frame_next = {dat_sync[1], frame[10:1]};

    // Start low, odd parity over data and parity bit, stop high
    assign frame_ok = ~frame_next[0] & (^frame_next[9:1]) & frame_next[10];

    always_ff @(posedge CLOCK_50) begin
        if (clk_fall) begin
            frame <= frame_next;
        end
    end

    always_ff @(posedge CLOCK_50 or negedge arst_n) begin
        if (!arst_n) begin
            bit_cnt    <= '0;
            scan_valid <= 1'b0;
            scan       <= '0;
        end else begin
            scan_valid <= 1'b0;
            if (clk_fall) begin
                if (bit_cnt == 4'd10) begin
                    bit_cnt <= '0;
                    // Bad frames just vanish
                    if (frame_ok) begin
                        scan       <= frame_next[8:1];
                        scan_valid <= 1'b1;
                    end
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end
        end
    end

endmodule

// ==== verilog/board_pkg.sv ====
package board_pkg;

    // Widths with a meaning of their own
    typedef logic [7:0]  scan_t;
    typedef logic [7:0]  ascii_t;
    typedef logic [31:0] wb_addr_t;
    typedef logic [31:0] wb_data_t;

    // Wishbone classic request, write only
    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        wb_addr_t adr;
        wb_data_t dat;
    } wb_req_t;

    // Slave response, room left for read data later
    typedef struct packed {
        logic ack;
    } wb_rsp_t;

    // One decoded key press
    typedef struct packed {
        logic   valid;
        ascii_t ascii;
    } key_evt_t;

    // Address map
    localparam wb_addr_t uart_base = 32'h8000_0000;
    localparam wb_addr_t led_base  = 32'h8000_0010;

    // 50 MHz / 115200 baud
    localparam int unsigned uart_div_default = 434;

endpackage
